//--- cgra_pkg.sv
package cgra_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  thread_t;
  typedef logic [7:0]  pc_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [3:0]  op_t;
  typedef logic [7:0]  pe_id_t;
  typedef logic [3:0]  conf_cmd_t;
  typedef logic [63:0] conf_word_t;

  localparam int NUM_THREADS = 8;
  localparam int PIPE_DEPTH  = 4; // Enabled cycles from issue to visible result
  localparam int IMEM_WORDS  = 2048; // 256 slots per thread
  localparam int RF_WORDS    = 128;  // 16 registers per thread

  // Configuration word fields
  localparam int CONF_PE_MSB     = 63;
  localparam int CONF_PE_LSB     = 56;
  localparam int CONF_CMD_MSB    = 55;
  localparam int CONF_CMD_LSB    = 52;
  localparam int CONF_THREAD_MSB = 51;
  localparam int CONF_THREAD_LSB = 49;
  localparam int CONF_ADDR_MSB   = 48;
  localparam int CONF_ADDR_LSB   = 41;
  localparam int CONF_DATA_MSB   = 15;
  localparam int CONF_DATA_LSB   = 0;

  localparam conf_cmd_t CMD_IDLE    = 4'd0;
  localparam conf_cmd_t CMD_INST    = 4'd1;
  localparam conf_cmd_t CMD_CONST   = 4'd2;
  localparam conf_cmd_t CMD_PC_MAX  = 4'd3;
  localparam conf_cmd_t CMD_PC_LOOP = 4'd4;
  localparam conf_cmd_t CMD_IGNORE  = 4'd5;

  // Instruction fields
  localparam int INST_OP_MSB    = 15;
  localparam int INST_OP_LSB    = 12;
  localparam int INST_SRC_B_RF  = 11;
  localparam int INST_RF_WE     = 10;
  localparam int INST_FIFO_PUSH = 9;
  localparam int INST_OUT_A_EN  = 8;
  localparam int INST_OUT_B_EN  = 7;
  localparam int INST_REG_MSB   = 6;
  localparam int INST_REG_LSB   = 3;

  localparam op_t OP_NOP    = 4'd0;
  localparam op_t OP_ADD    = 4'd1;
  localparam op_t OP_SUB    = 4'd2;
  localparam op_t OP_AND    = 4'd3;
  localparam op_t OP_OR     = 4'd4;
  localparam op_t OP_XOR    = 4'd5;
  localparam op_t OP_PASS_A = 4'd6;
  localparam op_t OP_PASS_B = 4'd7;
  localparam op_t OP_SHL    = 4'd8;
  localparam op_t OP_MUL    = 4'd9;

endpackage

//--- conf_if.sv
`timescale 1ns/1ns

interface conf_if;
  import cgra_pkg::*;

  logic      inst_we;
  pc_t       inst_addr;
  word_t     inst_data;
  logic      const_we;
  reg_addr_t const_addr;
  word_t     const_data;
  logic      pc_max_we;
  logic      pc_loop_we;
  logic      ignore_we;
  pc_t       bound_data; // Shared by max, loop and ignore writes
  thread_t   thread;

  modport src (
    output inst_we, inst_addr, inst_data,
    output const_we, const_addr, const_data,
    output pc_max_we, pc_loop_we, ignore_we,
    output bound_data, thread
  );

  modport dst (
    input inst_we, inst_addr, inst_data,
    input const_we, const_addr, const_data,
    input pc_max_we, pc_loop_we, ignore_we,
    input bound_data, thread
  );

endinterface

//--- conf_reader.sv
`timescale 1ns/1ns

module conf_reader #(
  parameter cgra_pkg::pe_id_t PE_ID = 8'd0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cgra_pkg::conf_word_t conf_bus_in,
  conf_if.src                  conf
);
  import cgra_pkg::*;

  pe_id_t    word_pe;
  conf_cmd_t word_cmd;
  thread_t   word_thread;
  pc_t       word_addr;
  word_t     word_data;
  logic      hit;

  assign word_pe     = conf_bus_in[CONF_PE_MSB:CONF_PE_LSB];
  assign word_cmd    = conf_bus_in[CONF_CMD_MSB:CONF_CMD_LSB];
  assign word_thread = conf_bus_in[CONF_THREAD_MSB:CONF_THREAD_LSB];
  assign word_addr   = conf_bus_in[CONF_ADDR_MSB:CONF_ADDR_LSB];
  assign word_data   = conf_bus_in[CONF_DATA_MSB:CONF_DATA_LSB];

  // Words for other PEs pass by untouched
  assign hit = (word_pe == PE_ID) && (word_cmd != CMD_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      conf.inst_we    <= 1'b0;
      conf.const_we   <= 1'b0;
      conf.pc_max_we  <= 1'b0;
      conf.pc_loop_we <= 1'b0;
      conf.ignore_we  <= 1'b0;
    end else begin
      conf.inst_we    <= hit && (word_cmd == CMD_INST);
      conf.const_we   <= hit && (word_cmd == CMD_CONST);
      conf.pc_max_we  <= hit && (word_cmd == CMD_PC_MAX);
      conf.pc_loop_we <= hit && (word_cmd == CMD_PC_LOOP);
      conf.ignore_we  <= hit && (word_cmd == CMD_IGNORE);
    end
  end

  // Payload follows the bus word every cycle
  always_ff @(posedge clk) begin
    conf.thread     <= word_thread;
    conf.inst_addr  <= word_addr;
    conf.inst_data  <= word_data;
    conf.const_addr <= word_addr[3:0]; // RF slice is 16 deep
    conf.const_data <= word_data;
    conf.bound_data <= word_data[7:0];
  end

endmodule

//--- thread_sequencer.sv
`timescale 1ns/1ns

module thread_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  conf_if.dst               conf,
  output cgra_pkg::thread_t thread,
  output cgra_pkg::pc_t     pc
);
  import cgra_pkg::*;

  pc_t pc_max  [NUM_THREADS];
  pc_t pc_loop [NUM_THREADS];
  pc_t pcs     [NUM_THREADS];

  // Bounds from configuration
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_THREADS; i++) begin
        pc_max[i]  <= '0;
        pc_loop[i] <= '0;
      end
    end else begin
      if (conf.pc_max_we)
        pc_max[conf.thread] <= conf.bound_data;
      if (conf.pc_loop_we)
        pc_loop[conf.thread] <= conf.bound_data;
    end
  end

  // One slot per enabled cycle in strict round robin
  always_ff @(posedge clk) begin
    if (reset)
      thread <= '0;
    else if (en)
      thread <= thread_t'(thread + 1'b1);
  end

  // Only the issuing thread moves its counter
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_THREADS; i++)
        pcs[i] <= '0;
    end else if (en) begin
      if (pcs[thread] >= pc_max[thread])
        pcs[thread] <= pc_loop[thread]; // Wrap back to loop start
      else
        pcs[thread] <= pc_t'(pcs[thread] + 1'b1);
    end
  end

  assign pc = pcs[thread];

endmodule

//--- output_filter.sv
`timescale 1ns/1ns

module output_filter (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  conf_if.dst               conf,
  input  cgra_pkg::thread_t push_thread,
  input  logic              push,
  output logic              fifo_we
);
  import cgra_pkg::*;

  pc_t  ignore_lim [NUM_THREADS];
  pc_t  ignore_cnt [NUM_THREADS];
  logic passed;

  // Thread has already dropped its warm-up pushes
  assign passed = (ignore_cnt[push_thread] >= ignore_lim[push_thread]);

  assign fifo_we = push & passed & en;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_THREADS; i++)
        ignore_lim[i] <= '0;
    end else if (conf.ignore_we) begin
      ignore_lim[conf.thread] <= conf.bound_data;
    end
  end

  // Count blocked pushes up to the limit
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_THREADS; i++)
        ignore_cnt[i] <= '0;
    end else if (en && push && !passed) begin
      ignore_cnt[push_thread] <= pc_t'(ignore_cnt[push_thread] + 1'b1);
    end
  end

endmodule

//--- pe_alu.sv
`timescale 1ns/1ns

module pe_alu (
  input  logic            clk,
  input  logic            en,
  input  cgra_pkg::op_t   op,
  input  cgra_pkg::word_t a,
  input  cgra_pkg::word_t b,
  output cgra_pkg::word_t result
);
  import cgra_pkg::*;

  word_t calc;

  always_comb begin
    case (op)
      OP_NOP:    calc = '0;
      OP_ADD:    calc = a + b;
      OP_SUB:    calc = a - b;
      OP_AND:    calc = a & b;
      OP_OR:     calc = a | b;
      OP_XOR:    calc = a ^ b;
      OP_PASS_A: calc = a;
      OP_PASS_B: calc = b;
      OP_SHL:    calc = a << b[3:0];
      OP_MUL:    calc = a * b; // Low half of product
      default:   calc = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (en)
      result <= calc;
  end

endmodule

//--- pe_out.sv
`timescale 1ns/1ns

module pe_out (
  input  logic            clk,
  input  logic            reset,
  input  logic            en,
  conf_if.dst             conf,
  input  cgra_pkg::word_t ina,
  input  cgra_pkg::word_t inb,
  output cgra_pkg::word_t outa,
  output cgra_pkg::word_t outb,
  output cgra_pkg::word_t fifo_data,
  output logic            fifo_we
);
  import cgra_pkg::*;

  thread_t   thread;
  pc_t       pc;
  thread_t   thread_pipe [1:PIPE_DEPTH]; // Thread of the slot in each stage
  word_t     imem [IMEM_WORDS];
  word_t     rf   [RF_WORDS];
  word_t     inst_q;
  word_t     inst_dec;
  logic      primed;
  op_t       op_q2;
  logic      src_b_rf_q2;
  word_t     ina_q2;
  word_t     inb_q2;
  word_t     rf_q2;
  word_t     alu_b;
  word_t     alu_result;
  logic      rf_we_q2, rf_we_q3;
  logic      push_q2, push_q3, push_q4;
  logic      out_a_q2, out_a_q3;
  logic      out_b_q2, out_b_q3;
  reg_addr_t reg_q2, reg_q3;

  thread_sequencer u_seq (
    .clk    (clk),
    .reset  (reset),
    .en     (en),
    .conf   (conf),
    .thread (thread),
    .pc     (pc)
  );

  // Fetch
  always_ff @(posedge clk) begin
    if (conf.inst_we)
      imem[{conf.thread, conf.inst_addr}] <= conf.inst_data;
    if (en)
      inst_q <= imem[{thread, pc}];
  end

  always_ff @(posedge clk) begin
    if (en) begin
      thread_pipe[1] <= thread;
      for (int i = 2; i <= PIPE_DEPTH; i++)
        thread_pipe[i] <= thread_pipe[i-1];
    end
  end

  // Fetch register holds nothing valid before the first enabled cycle
  always_ff @(posedge clk) begin
    if (reset)
      primed <= 1'b0;
    else if (en)
      primed <= 1'b1;
  end

  assign inst_dec = primed ? inst_q : '0;

  // Decode and operand stage
  always_ff @(posedge clk) begin
    if (en) begin
      op_q2       <= inst_dec[INST_OP_MSB:INST_OP_LSB];
      src_b_rf_q2 <= inst_dec[INST_SRC_B_RF];
      reg_q2      <= inst_dec[INST_REG_MSB:INST_REG_LSB];
      ina_q2      <= ina;
      inb_q2      <= inb;
      rf_q2       <= rf[{thread_pipe[1], inst_dec[INST_REG_MSB:INST_REG_LSB]}];
      reg_q3      <= reg_q2;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      {rf_we_q2, push_q2, out_a_q2, out_b_q2} <= '0;
      {rf_we_q3, push_q3, out_a_q3, out_b_q3} <= '0;
      push_q4 <= 1'b0;
    end else if (en) begin
      rf_we_q2 <= inst_dec[INST_RF_WE];
      push_q2  <= inst_dec[INST_FIFO_PUSH];
      out_a_q2 <= inst_dec[INST_OUT_A_EN];
      out_b_q2 <= inst_dec[INST_OUT_B_EN];
      {rf_we_q3, push_q3, out_a_q3, out_b_q3} <= {rf_we_q2, push_q2, out_a_q2, out_b_q2};
      push_q4 <= push_q3;
    end
  end

  assign alu_b = src_b_rf_q2 ? rf_q2 : inb_q2;

  pe_alu u_alu (
    .clk    (clk),
    .en     (en),
    .op     (op_q2),
    .a      (ina_q2),
    .b      (alu_b),
    .result (alu_result)
  );

  // Configuration constants win over write-back
  always_ff @(posedge clk) begin
    if (conf.const_we)
      rf[{conf.thread, conf.const_addr}] <= conf.const_data;
    else if (en && rf_we_q3)
      rf[{thread_pipe[3], reg_q3}] <= alu_result;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      outa      <= '0;
      outb      <= '0;
      fifo_data <= '0;
    end else if (en) begin
      fifo_data <= alu_result;
      if (out_a_q3)
        outa <= alu_result;
      if (out_b_q3)
        outb <= alu_result;
    end
  end

  output_filter u_filter (
    .clk         (clk),
    .reset       (reset),
    .en          (en),
    .conf        (conf),
    .push_thread (thread_pipe[PIPE_DEPTH]),
    .push        (push_q4),
    .fifo_we     (fifo_we)
  );

endmodule

//--- pe_out_top.sv
`timescale 1ns/1ns

module pe_out_top #(
  parameter cgra_pkg::pe_id_t PE_ID = 8'd0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 en,
  input  cgra_pkg::conf_word_t conf_bus_in,
  input  cgra_pkg::word_t      ina,
  input  cgra_pkg::word_t      inb,
  output cgra_pkg::word_t      outa,
  output cgra_pkg::word_t      outb,
  output cgra_pkg::word_t      fifo_data,
  output logic                 fifo_we
);

  conf_if conf ();

  conf_reader #(
    .PE_ID (PE_ID)
  ) u_conf_reader (
    .clk         (clk),
    .reset       (reset),
    .conf_bus_in (conf_bus_in),
    .conf        (conf)
  );

  pe_out u_pe (
    .clk       (clk),
    .reset     (reset),
    .en        (en),
    .conf      (conf),
    .ina       (ina),
    .inb       (inb),
    .outa      (outa),
    .outb      (outb),
    .fifo_data (fifo_data),
    .fifo_we   (fifo_we)
  );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 4
) (
  input  logic restart,
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

  // Reset at time zero and again on every restart request
  always begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge restart);
  end

endmodule

//--- pe_out_checker.sv
`timescale 1ns/1ns

module pe_out_checker (
  input logic            clk,
  input logic            reset,
  input logic            en,
  input logic            fifo_we,
  input cgra_pkg::word_t outa,
  input cgra_pkg::word_t outb,
  input logic [4:0]      strobes
);

  a_no_push_in_reset: assert property (@(posedge clk) reset |-> !fifo_we)
    else $error("fifo_we high during reset");

  a_push_needs_en: assert property (@(posedge clk) disable iff (reset) fifo_we |-> en)
    else $error("fifo_we high while en is low");

  // Frozen outputs while stalled
  a_out_stable: assert property (@(posedge clk)
    (!en && !reset) |=> ($stable(outa) && $stable(outb)))
    else $error("outa or outb changed while en is low");

  a_one_strobe: assert property (@(posedge clk) disable iff (reset) $onehot0(strobes))
    else $error("more than one configuration strobe active");

endmodule

bind pe_out_top pe_out_checker u_checker (
  .clk     (clk),
  .reset   (reset),
  .en      (en),
  .fifo_we (fifo_we),
  .outa    (outa),
  .outb    (outb),
  .strobes ({conf.inst_we, conf.const_we, conf.pc_max_we, conf.pc_loop_we, conf.ignore_we})
);

//--- pe_out_tb.sv
`timescale 1ns/1ns

module pe_out_tb;
  import cgra_pkg::*;

  localparam pe_id_t PE_ID_DUT  = 8'd3;
  localparam int     TIMEOUT    = 2000;
  localparam int     SLOTS      = 96; // Twelve rounds of all threads
  localparam int     SLOT_WORDS = IMEM_WORDS / NUM_THREADS;
  localparam int     RF_SLICE   = RF_WORDS / NUM_THREADS;

  // Instruction flag bits 11 down to 7
  localparam logic [4:0] F_SRC_RF = 5'b10000;
  localparam logic [4:0] F_RF_WE  = 5'b01000;
  localparam logic [4:0] F_PUSH   = 5'b00100;
  localparam logic [4:0] F_OUT_A  = 5'b00010;
  localparam logic [4:0] F_OUT_B  = 5'b00001;

  logic       clk;
  logic       reset;
  logic       restart;
  logic       en;
  conf_word_t conf_bus_in;
  word_t      ina;
  word_t      inb;
  word_t      outa;
  word_t      outb;
  word_t      fifo_data;
  logic       fifo_we;

  // What configuration has put into the PE
  word_t prog_m [IMEM_WORDS];
  word_t rf_m   [RF_WORDS];
  pc_t   max_m  [NUM_THREADS];
  pc_t   loop_m [NUM_THREADS];
  pc_t   ign_m  [NUM_THREADS];
  word_t ina_val;
  word_t inb_val;
  word_t exp_outa;
  word_t exp_outb;

  word_t  exp_q [$];
  word_t  got_q [$];
  word_t  got_word;
  word_t  want_word;
  string  cur_test;
  integer seed;
  int     test_errors;
  int     total_errors;
  int     tests_run;
  int     tests_failed;

  tb_clock #(.PERIOD(10), .RESET_CYCLES(4)) u_clock (
    .restart (restart),
    .clk     (clk),
    .reset   (reset)
  );

  pe_out_top #(.PE_ID(PE_ID_DUT)) dut0 (
    .clk         (clk),
    .reset       (reset),
    .en          (en),
    .conf_bus_in (conf_bus_in),
    .ina         (ina),
    .inb         (inb),
    .outa        (outa),
    .outb        (outb),
    .fifo_data   (fifo_data),
    .fifo_we     (fifo_we)
  );

  function automatic word_t alu_ref(input op_t op, input word_t a, input word_t b);
    case (op)
      OP_ADD:    return a + b;
      OP_SUB:    return a - b;
      OP_AND:    return a & b;
      OP_OR:     return a | b;
      OP_XOR:    return a ^ b;
      OP_PASS_A: return a;
      OP_PASS_B: return b;
      OP_SHL:    return a << b[3:0];
      OP_MUL:    return a * b;
      default:   return '0;
    endcase
  endfunction

  function automatic word_t make_inst(input op_t op, input logic [4:0] flags,
                                      input reg_addr_t rg);
    return {op, flags, rg, 3'b000};
  endfunction

  // Walks the issue slots in round-robin order and lists the pushes that survive
  function automatic void build_expected(input int num_slots);
    pc_t   pcs  [NUM_THREADS];
    int    seen [NUM_THREADS];
    word_t rf   [RF_WORDS];
    word_t inst;
    word_t b;
    word_t r;
    int    t;
    int    ra;
    exp_q.delete();
    exp_outa = '0;
    exp_outb = '0;
    for (int i = 0; i < NUM_THREADS; i++) begin
      pcs[i]  = '0;
      seen[i] = 0;
    end
    for (int i = 0; i < RF_WORDS; i++)
      rf[i] = rf_m[i];
    for (int s = 0; s < num_slots; s++) begin
      t    = s % NUM_THREADS;
      inst = prog_m[t * SLOT_WORDS + pcs[t]];
      ra   = t * RF_SLICE + inst[INST_REG_MSB:INST_REG_LSB];
      b    = inst[INST_SRC_B_RF] ? rf[ra] : inb_val;
      r    = alu_ref(inst[INST_OP_MSB:INST_OP_LSB], ina_val, b);
      if (inst[INST_RF_WE])
        rf[ra] = r; // Lands before the thread's next slot reads it
      if (inst[INST_OUT_A_EN])
        exp_outa = r;
      if (inst[INST_OUT_B_EN])
        exp_outb = r;
      if (inst[INST_FIFO_PUSH]) begin
        if (seen[t] >= ign_m[t])
          exp_q.push_back(r);
        else
          seen[t]++;
      end
      if (pcs[t] >= max_m[t])
        pcs[t] = loop_m[t];
      else
        pcs[t] = pcs[t] + 8'd1;
    end
  endfunction

  task automatic send_conf(input pe_id_t pe, input conf_cmd_t cmd, input thread_t thr,
                           input pc_t addr, input word_t data);
    conf_bus_in = {pe, cmd, thr, addr, 25'd0, data};
    if (pe == PE_ID_DUT) begin
      case (cmd)
        CMD_INST:    prog_m[thr * SLOT_WORDS + addr] = data;
        CMD_CONST:   rf_m[thr * RF_SLICE + addr[3:0]] = data;
        CMD_PC_MAX:  max_m[thr] = data[7:0];
        CMD_PC_LOOP: loop_m[thr] = data[7:0];
        CMD_IGNORE:  ign_m[thr] = data[7:0];
        default:     ;
      endcase
    end
    @(posedge clk);
    #1;
    conf_bus_in = '0;
  endtask

  task automatic write_inst(input thread_t thr, input pc_t addr, input word_t inst);
    send_conf(PE_ID_DUT, CMD_INST, thr, addr, inst);
  endtask

  task automatic set_bounds(input thread_t thr, input pc_t max, input pc_t loop);
    send_conf(PE_ID_DUT, CMD_PC_MAX, thr, 8'd0, {8'd0, max});
    send_conf(PE_ID_DUT, CMD_PC_LOOP, thr, 8'd0, {8'd0, loop});
  endtask

  task automatic restart_dut;
    int n;
    restart = 1'b1;
    @(posedge clk);
    #1;
    restart = 1'b0;
    n = 0;
    while (reset && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (reset) begin
      $display("%s: reset never deasserted", cur_test);
      test_errors++;
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_THREADS; i++) begin
      max_m[i]  = '0;
      loop_m[i] = '0;
      ign_m[i]  = '0;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
    restart_dut();
    ina_val = word_t'($random(seed));
    inb_val = word_t'($random(seed));
    ina     = ina_val;
    inb     = inb_val;
    for (int t = 0; t < NUM_THREADS; t++)
      write_inst(thread_t'(t), 8'd0, '0);
  endtask

  // Runs the PE until every expected push has come out
  task automatic run_stream(input bit stall);
    int n;
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    build_expected(SLOTS);
    n = 0;
    while (exp_q.size() > 0 && n < TIMEOUT) begin
      if (stall)
        en = ($random(seed) & 3) != 0;
      else
        en = 1'b1;
      @(posedge clk);
      #1;
      n++;
    end
    en = 1'b0;
    if (exp_q.size() > 0) begin
      $display("%s: timed out with %0d FIFO pushes still missing", cur_test, exp_q.size());
      test_errors++;
    end
  endtask

  task automatic end_test;
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, test_errors);
    end
  endtask

  // FIFO monitor
  always @(negedge clk) begin
    if (fifo_we && !en) begin
      $display("%s: fifo_we high while en is low", cur_test);
      test_errors++;
    end
    if (fifo_we)
      got_q.push_back(fifo_data);
  end

  always @(posedge clk) begin
    while (got_q.size() > 0) begin
      got_word = got_q.pop_front();
      if (exp_q.size() == 0) begin
        $display("%s: FIFO push of %h when none was expected", cur_test, got_word);
        test_errors++;
      end else begin
        want_word = exp_q.pop_front();
        if (got_word != want_word) begin
          $display("FAIL %s: expected %h, got %h", cur_test, want_word, got_word);
          test_errors++;
        end
      end
    end
  end

  initial begin
    int n;
    seed         = 32'h5bbe12f5;
    restart      = 1'b0;
    en           = 1'b0;
    conf_bus_in  = '0;
    ina          = '0;
    inb          = '0;
    cur_test     = "startup";
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    n = 0;
    while (reset !== 1'b0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (reset !== 1'b0) begin
      $display("Initial reset never deasserted");
      total_errors++;
    end
    @(posedge clk);
    #1;

    begin_test("basic");
    write_inst(3'd0, 8'd0, make_inst(OP_ADD, F_PUSH, 4'd0));
    write_inst(3'd0, 8'd1, make_inst(OP_XOR, F_PUSH, 4'd0));
    write_inst(3'd0, 8'd2, make_inst(OP_SUB, F_PUSH, 4'd0));
    write_inst(3'd0, 8'd3, make_inst(OP_PASS_A, F_PUSH, 4'd0));
    write_inst(3'd0, 8'd4, make_inst(OP_OR, F_OUT_A | F_OUT_B, 4'd0));
    set_bounds(3'd0, 8'd4, 8'd0);
    run_stream(1'b0);
    repeat (5) begin
      @(posedge clk);
      #1;
    end
    if (outa !== exp_outa) begin
      $display("FAIL %s outa: expected %h, got %h", cur_test, exp_outa, outa);
      test_errors++;
    end
    if (outb !== exp_outb) begin
      $display("FAIL %s outb: expected %h, got %h", cur_test, exp_outb, outb);
      test_errors++;
    end
    end_test();

    begin_test("register_file");
    send_conf(PE_ID_DUT, CMD_CONST, 3'd1, 8'd0, word_t'($random(seed)));
    send_conf(PE_ID_DUT, CMD_CONST, 3'd1, 8'd1, word_t'($random(seed)));
    write_inst(3'd1, 8'd0, make_inst(OP_ADD, F_SRC_RF | F_PUSH, 4'd0));
    write_inst(3'd1, 8'd1, make_inst(OP_XOR, F_SRC_RF | F_RF_WE | F_PUSH, 4'd1));
    write_inst(3'd1, 8'd2, make_inst(OP_ADD, F_SRC_RF | F_RF_WE | F_PUSH, 4'd1));
    write_inst(3'd1, 8'd3, make_inst(OP_MUL, F_SRC_RF | F_PUSH, 4'd1));
    set_bounds(3'd1, 8'd3, 8'd1);
    run_stream(1'b0);
    end_test();

    begin_test("looping");
    write_inst(3'd2, 8'd0, make_inst(OP_ADD, F_PUSH, 4'd0));
    write_inst(3'd2, 8'd1, make_inst(OP_SUB, F_PUSH, 4'd0));
    write_inst(3'd2, 8'd2, make_inst(OP_XOR, F_PUSH, 4'd0));
    write_inst(3'd2, 8'd3, make_inst(OP_SHL, F_PUSH, 4'd0));
    set_bounds(3'd2, 8'd3, 8'd1);
    run_stream(1'b0);
    end_test();

    begin_test("ignore");
    write_inst(3'd5, 8'd0, make_inst(OP_ADD, F_PUSH, 4'd0));
    write_inst(3'd5, 8'd1, make_inst(OP_MUL, F_PUSH, 4'd0));
    set_bounds(3'd5, 8'd1, 8'd0);
    send_conf(PE_ID_DUT, CMD_IGNORE, 3'd5, 8'd0, 16'd3);
    run_stream(1'b0);
    end_test();

    begin_test("stalls");
    // outa and outb keep changing so that frozen outputs are observable
    write_inst(3'd0, 8'd0, make_inst(OP_ADD, F_PUSH | F_OUT_B, 4'd0));
    write_inst(3'd0, 8'd1, make_inst(OP_MUL, F_PUSH | F_OUT_B, 4'd0));
    set_bounds(3'd0, 8'd1, 8'd0);
    write_inst(3'd3, 8'd0, make_inst(OP_SHL, F_PUSH, 4'd0));
    write_inst(3'd3, 8'd1, make_inst(OP_OR, F_PUSH | F_OUT_A, 4'd0));
    write_inst(3'd3, 8'd2, make_inst(OP_PASS_B, F_PUSH | F_OUT_A, 4'd0));
    set_bounds(3'd3, 8'd2, 8'd0);
    write_inst(3'd6, 8'd0, make_inst(OP_XOR, F_PUSH, 4'd0));
    write_inst(3'd6, 8'd1, make_inst(OP_AND, F_PUSH, 4'd0));
    set_bounds(3'd6, 8'd1, 8'd1);
    write_inst(3'd7, 8'd0, make_inst(OP_PASS_A, F_PUSH, 4'd0));
    send_conf(PE_ID_DUT, CMD_IGNORE, 3'd7, 8'd0, 16'd2);
    run_stream(1'b1);
    end_test();

    begin_test("addressing");
    write_inst(3'd4, 8'd0, make_inst(OP_ADD, F_PUSH, 4'd0));
    write_inst(3'd4, 8'd1, make_inst(OP_SUB, F_PUSH, 4'd0));
    set_bounds(3'd4, 8'd1, 8'd0);
    // Words for other PEs
    send_conf(8'd7, CMD_INST, 3'd4, 8'd0, make_inst(OP_MUL, F_PUSH, 4'd0));
    send_conf(8'h13, CMD_PC_MAX, 3'd4, 8'd0, 16'd5);
    send_conf(8'd2, CMD_IGNORE, 3'd4, 8'd0, 16'd2);
    send_conf(8'hff, CMD_INST, 3'd0, 8'd0, make_inst(OP_XOR, F_PUSH, 4'd0));
    run_stream(1'b0);
    end_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- filelist.f
cgra_pkg.sv
conf_if.sv
conf_reader.sv
thread_sequencer.sv
output_filter.sv
pe_alu.sv
pe_out.sv
pe_out_top.sv
tb_clock.sv
pe_out_checker.sv
pe_out_tb.sv
